//--- ldst_unit.f
hdl/ldst_pkg.sv
hdl/ldst_addr_gen.sv
hdl/ldst_buffer.sv
hdl/ldst_mem_ctrl.sv
hdl/ldst_unit.sv
bench/tb_clock_gen.sv
bench/data_mem_model.sv
bench/ldst_unit_tb.sv

//--- Makefile
# Verilator simulation of the load/store unit

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module ldst_unit_tb \
		-f ldst_unit.f -Mdir obj_dir
	out=$$(./obj_dir/Vldst_unit_tb); echo "$$out"; \
		echo "$$out" | grep -qx "Finished with no errors"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- bench/ldst_unit_tb.sv
/*
 * Load/store unit testbench
 * Directed tests for word and narrow accesses, queue back-pressure,
 * program order and misaligned faults, against a bench byte array
 */
`timescale 1ns/100ps
`default_nettype none

module ldst_unit_tb;

    import ldst_pkg::*;

    localparam int unsigned DRIVE_DLY    = 10;
    localparam int unsigned RESET_CYCLES = 8;
    // Five tests, up to 40 ops each, about 20 cycles per handshake
    localparam int unsigned TIMEOUT_CYCLES = 5 * 40 * 20;

    logic                  clk;
    logic                  reset_n;
    logic                  disp_valid;
    logic [LDST_OP_W-1:0]  disp_op;
    logic [LDST_XLEN-1:0]  disp_base;
    logic [LDST_XLEN-1:0]  disp_offset;
    ldst_payload_u         disp_payload;
    logic                  disp_ready;
    logic                  mem_req;
    logic                  mem_we;
    logic [LDST_XLEN-1:0]  mem_addr;
    logic [3:0]            mem_be;
    logic [LDST_XLEN-1:0]  mem_wdata;
    logic                  mem_ack;
    logic [LDST_XLEN-1:0]  mem_rdata;
    logic                  res_valid;
    logic [LDST_TAG_W-1:0] res_tag;
    logic [LDST_XLEN-1:0]  res_data;
    logic                  res_fault;
    logic [3:0]            ack_delay;
    logic                  hold_ack;

    // Reference memory, little-endian bytes
    logic [7:0]            ref_mem [1024];
    logic [31:0]           lfsr_state = 32'h1829;

    // Outstanding load results in dispatch order
    logic [LDST_TAG_W-1:0] exp_tag_q [$];
    logic [LDST_XLEN-1:0]  exp_data_q [$];
    logic                  exp_fault_q [$];
    // Writes seen at the memory port as {addr, wdata}
    logic [63:0]           wr_log_q [$];

    int err_cnt    = 0;
    int check_cnt  = 0;
    int cycle_cnt  = 0;
    int mem_issued = 0;
    int mem_done   = 0;

    tb_clock_gen i_tb_clock_gen (
        .clk_o (clk)
    );

    data_mem_model i_data_mem_model (
        .clk_i       (clk),
        .reset_n_i   (reset_n),
        .req_i       (mem_req),
        .we_i        (mem_we),
        .addr_i      (mem_addr),
        .be_i        (mem_be),
        .wdata_i     (mem_wdata),
        .ack_delay_i (ack_delay),
        .hold_ack_i  (hold_ack),
        .ack_o       (mem_ack),
        .rdata_o     (mem_rdata)
    );

    ldst_unit i_ldst_unit (
        .clk_i          (clk),
        .reset_n_i      (reset_n),
        .disp_valid_i   (disp_valid),
        .disp_op_i      (disp_op),
        .disp_base_i    (disp_base),
        .disp_offset_i  (disp_offset),
        .disp_payload_i (disp_payload),
        .disp_ready_o   (disp_ready),
        .mem_req_o      (mem_req),
        .mem_we_o       (mem_we),
        .mem_addr_o     (mem_addr),
        .mem_be_o       (mem_be),
        .mem_wdata_o    (mem_wdata),
        .mem_ack_i      (mem_ack),
        .mem_rdata_i    (mem_rdata),
        .res_valid_o    (res_valid),
        .res_tag_o      (res_tag),
        .res_data_o     (res_data),
        .res_fault_o    (res_fault)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    function automatic int access_size(input logic [LDST_OP_W-1:0] op);
        case (op)
            OP_LH, OP_LHU, OP_SH: return 2;
            OP_LW, OP_SW: return 4;
            default: return 1;
        endcase
    endfunction

    function automatic logic is_store_op(input logic [LDST_OP_W-1:0] op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    // Gather bytes from the reference array, then extend by op
    function automatic logic [LDST_XLEN-1:0] expect_load(input logic [LDST_OP_W-1:0] op,
                                                         input logic [LDST_XLEN-1:0] addr);
        logic [LDST_XLEN-1:0] val;
        val = '0;
        for (int i = access_size(op) - 1; i >= 0; i--) begin
            val = {val[23:0], ref_mem[addr[9:0] + i]};
        end
        if (op == OP_LB) begin
            val = {{24{val[7]}}, val[7:0]};
        end else if (op == OP_LH) begin
            val = {{16{val[15]}}, val[15:0]};
        end
        return val;
    endfunction

    task automatic check_data(input logic [LDST_XLEN-1:0] got,
                              input logic [LDST_XLEN-1:0] exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_tag(input logic [LDST_TAG_W-1:0] got,
                             input logic [LDST_TAG_W-1:0] exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_fault(input logic got, input logic exp, input string what);
        check_cnt++;
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // Present one op for one cycle, book it if it was accepted
    task automatic offer_op(input logic [LDST_OP_W-1:0] op, input logic [LDST_XLEN-1:0] addr,
                            input logic [LDST_TAG_W-1:0] tag, output logic accepted,
                            output logic [LDST_XLEN-1:0] data);
        logic [31:0] offset;
        logic        misaligned;
        int          size;
        take_bits(32, data);
        take_bits(8, offset);
        size = access_size(op);
        misaligned = (addr % size) != 0;
        disp_valid  = 1'b1;
        disp_op     = op;
        disp_offset = offset;
        disp_base   = addr - offset;
        disp_payload = '0;
        if (is_store_op(op)) begin
            disp_payload.store_data = data;
        end else begin
            disp_payload.load.dest_tag = tag;
        end
        // Ready is stable by mid-cycle and holds through the edge
        @(negedge clk);
        accepted = disp_ready;
        @(posedge clk);
        #DRIVE_DLY;
        disp_valid = 1'b0;
        if (accepted) begin
            if (!misaligned) begin
                mem_issued++;
            end
            if (is_store_op(op) && !misaligned) begin
                for (int i = 0; i < size; i++) begin
                    ref_mem[addr[9:0] + i] = data[8*i +: 8];
                end
            end else if (!is_store_op(op)) begin
                exp_tag_q.push_back(tag);
                exp_fault_q.push_back(misaligned);
                if (misaligned) begin
                    exp_data_q.push_back('0);
                end else begin
                    exp_data_q.push_back(expect_load(op, addr));
                end
            end
        end
    endtask

    task automatic send_op(input logic [LDST_OP_W-1:0] op, input logic [LDST_XLEN-1:0] addr,
                           input logic [LDST_TAG_W-1:0] tag, output logic [LDST_XLEN-1:0] data);
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            offer_op(op, addr, tag, accepted, data);
        end
    endtask

    // All loads answered and all aligned accesses handshaken
    task automatic wait_idle();
        while (exp_tag_q.size() != 0 || mem_done != mem_issued) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic test_word_store_load();
        logic [LDST_XLEN-1:0] data;
        int errs;
        errs = err_cnt;
        send_op(OP_SW, 32'h100, '0, data);
        send_op(OP_LW, 32'h100, 5'd1, data);
        wait_idle();
        report_test("word store and load", errs);
    endtask

    task automatic test_narrow_access();
        logic [LDST_XLEN-1:0] data;
        logic [LDST_TAG_W-1:0] tag;
        int errs;
        errs = err_cnt;
        tag = 5'd2;
        // Every byte lane of one word, both halves of the next
        for (int i = 0; i < 4; i++) begin
            send_op(OP_SB, 32'h200 + i, '0, data);
        end
        send_op(OP_SH, 32'h204, '0, data);
        send_op(OP_SH, 32'h206, '0, data);
        for (int i = 0; i < 4; i++) begin
            send_op(OP_LB, 32'h200 + i, tag, data);
            tag++;
            send_op(OP_LBU, 32'h200 + i, tag, data);
            tag++;
        end
        for (int i = 0; i < 2; i++) begin
            send_op(OP_LH, 32'h204 + 2 * i, tag, data);
            tag++;
            send_op(OP_LHU, 32'h204 + 2 * i, tag, data);
            tag++;
        end
        send_op(OP_LW, 32'h200, tag, data);
        wait_idle();
        report_test("narrow accesses", errs);
    endtask

    task automatic test_back_pressure();
        logic                 accepted;
        logic [LDST_XLEN-1:0] data;
        logic [LDST_XLEN-1:0] sent_q [$];
        int n_acc;
        int tries;
        int errs;
        errs = err_cnt;
        wr_log_q.delete();
        hold_ack = 1'b1;
        n_acc = 0;
        tries = 0;
        accepted = 1'b1;
        // Keep offering until the queue pushes back
        while (accepted && tries < 2 * LDST_DEPTH) begin
            offer_op(OP_SW, 32'h300 + 4 * n_acc, '0, accepted, data);
            tries++;
            if (accepted) begin
                n_acc++;
                sent_q.push_back(data);
            end
        end
        check_cnt++;
        if (n_acc != LDST_DEPTH + 1) begin
            $display("Fail at %0t ns: %0d stores accepted before ready fell, expected %0d",
                     $time, n_acc, LDST_DEPTH + 1);
            err_cnt++;
        end
        hold_ack = 1'b0;
        wait_idle();
        if (wr_log_q.size() != sent_q.size()) begin
            $display("Error: %0d stores reached memory but %0d were accepted",
                     wr_log_q.size(), sent_q.size());
            err_cnt++;
        end
        for (int i = 0; i < sent_q.size() && i < wr_log_q.size(); i++) begin
            check_data(wr_log_q[i][63:32], 32'h300 + 4 * i, "store address");
            check_data(wr_log_q[i][31:0], sent_q[i], "store data");
        end
        report_test("back-pressure", errs);
    endtask

    task automatic test_program_order();
        logic [31:0]           bits;
        logic [LDST_OP_W-1:0]  op;
        logic [LDST_XLEN-1:0]  data;
        logic [LDST_TAG_W-1:0] tag;
        int errs;
        errs = err_cnt;
        tag = 5'd16;
        // Whole word written first so every later load reads known bytes
        send_op(OP_SW, 32'h380, '0, data);
        for (int i = 0; i < 16; i++) begin
            take_bits(3, bits);
            ack_delay = {1'b0, bits[2:0]};
            take_bits(2, bits);
            case (bits[1:0])
                2'd0: op = OP_SW;
                2'd1: op = OP_LW;
                2'd2: op = OP_SH;
                default: op = OP_LHU;
            endcase
            send_op(op, 32'h380, tag, data);
            if (!is_store_op(op)) begin
                tag++;
            end
        end
        wait_idle();
        ack_delay = 4'd1;
        report_test("program order", errs);
    endtask

    task automatic test_misaligned();
        logic [LDST_XLEN-1:0] data;
        int errs;
        errs = err_cnt;
        send_op(OP_SW, 32'h3c0, '0, data);
        // Loads that fault
        send_op(OP_LW, 32'h3c1, 5'd20, data);
        send_op(OP_LH, 32'h3c3, 5'd21, data);
        // Stores that are dropped
        send_op(OP_SW, 32'h3c2, '0, data);
        send_op(OP_SH, 32'h3c1, '0, data);
        send_op(OP_LW, 32'h3c0, 5'd22, data);
        send_op(OP_LBU, 32'h3c1, 5'd23, data);
        wait_idle();
        report_test("misaligned accesses", errs);
    endtask

    // Load result checker, in dispatch order
    always @(negedge clk) begin
        if (reset_n && res_valid) begin
            if (exp_tag_q.size() == 0) begin
                $display("Error at %0t ns: load result with tag %0d but none outstanding",
                         $time, res_tag);
                err_cnt++;
            end else begin
                check_tag(res_tag, exp_tag_q.pop_front(), "result tag");
                if (exp_fault_q[0]) begin
                    void'(exp_data_q.pop_front());
                end else begin
                    check_data(res_data, exp_data_q.pop_front(), "result data");
                end
                check_fault(res_fault, exp_fault_q.pop_front(), "result fault");
            end
        end
    end

    // Handshake counter, one hit per req with ack
    always @(negedge clk) begin
        if (reset_n && mem_req && mem_ack) begin
            mem_done++;
            if (mem_we) begin
                wr_log_q.push_back({mem_addr, mem_wdata});
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped responding", cycle_cnt);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        reset_n      = 1'b0;
        disp_valid   = 1'b0;
        disp_op      = '0;
        disp_base    = '0;
        disp_offset  = '0;
        disp_payload = '0;
        ack_delay    = 4'd1;
        hold_ack     = 1'b0;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
        end
        #DRIVE_DLY;
        reset_n = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        test_word_store_load();
        test_narrow_access();
        test_back_pressure();
        test_program_order();
        test_misaligned();
        $display("Tests: 5, checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : ldst_unit_tb

`default_nettype wire

//--- bench/data_mem_model.sv
/*
 * Data memory model
 * Byte-enabled word array answering four-phase req/ack requests,
 * ack after an adjustable delay, stalled while hold_ack_i is high
 */
`timescale 1ns/100ps
`default_nettype none

module data_mem_model (
    input  wire logic        clk_i,
    input  wire logic        reset_n_i,
    input  wire logic        req_i,
    input  wire logic        we_i,
    input  wire logic [31:0] addr_i,
    input  wire logic [3:0]  be_i,
    input  wire logic [31:0] wdata_i,
    input  wire logic [3:0]  ack_delay_i,
    input  wire logic        hold_ack_i,
    output logic             ack_o,
    output logic [31:0]      rdata_o
);

    localparam int unsigned WORDS = 256;
    localparam int unsigned DRIVE_DLY = 10;

    logic [31:0] mem [WORDS];
    logic [3:0]  wait_cnt;
    logic        ack_nxt;
    logic [31:0] rdata_nxt;

    // Fill pattern from the full word index
    initial begin
        for (int i = 0; i < WORDS; i++) begin
            mem[i] = 32'h5a00_0000 ^ (i * 32'h0001_0203);
        end
        ack_o     = 1'b0;
        rdata_o   = '0;
        ack_nxt   = 1'b0;
        rdata_nxt = '0;
        wait_cnt  = '0;
    end

    // Decide mid-cycle, drive just after the next rising edge
    always begin
        @(negedge clk_i);
        ack_nxt = ack_o;
        if (!reset_n_i || !req_i) begin
            // Request gone, so ack falls
            ack_nxt  = 1'b0;
            wait_cnt = '0;
        end else if (!ack_o && !hold_ack_i) begin
            if (wait_cnt >= ack_delay_i) begin
                if (we_i) begin
                    for (int b = 0; b < 4; b++) begin
                        if (be_i[b]) begin
                            mem[addr_i[9:2]][8*b +: 8] = wdata_i[8*b +: 8];
                        end
                    end
                end
                rdata_nxt = mem[addr_i[9:2]];
                ack_nxt   = 1'b1;
            end else begin
                wait_cnt = wait_cnt + 1'b1;
            end
        end
        @(posedge clk_i);
        #DRIVE_DLY;
        ack_o   = ack_nxt;
        rdata_o = rdata_nxt;
    end

endmodule : data_mem_model

`default_nettype wire

//--- bench/tb_clock_gen.sv
/*
 * Testbench clock source
 * Free-running clock with a 100 ns period
 */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o
);

    localparam int unsigned HALF_PERIOD = 50;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD;
            clk_o = ~clk_o;
        end
    end

endmodule : tb_clock_gen

`default_nettype wire

//--- hdl/ldst_unit.sv
/*
 * Load/store unit top level
 * Address generation feeds the ordered queue, which feeds the
 * memory controller
 */
`timescale 1ns/100ps
`default_nettype none

module ldst_unit (
    input  wire logic                              clk_i,
    input  wire logic                              reset_n_i,

    // Dispatch
    input  wire logic                              disp_valid_i,
    input  wire logic [ldst_pkg::LDST_OP_W-1:0]    disp_op_i,
    input  wire logic [ldst_pkg::LDST_XLEN-1:0]    disp_base_i,
    input  wire logic [ldst_pkg::LDST_XLEN-1:0]    disp_offset_i,
    input  wire ldst_pkg::ldst_payload_u           disp_payload_i,
    output logic                                   disp_ready_o,

    // Data memory, four-phase
    output logic                                   mem_req_o,
    output logic                                   mem_we_o,
    output logic [ldst_pkg::LDST_XLEN-1:0]         mem_addr_o,
    output logic [3:0]                             mem_be_o,
    output logic [ldst_pkg::LDST_XLEN-1:0]         mem_wdata_o,
    input  wire logic                              mem_ack_i,
    input  wire logic [ldst_pkg::LDST_XLEN-1:0]    mem_rdata_i,

    // Load results
    output logic                                   res_valid_o,
    output logic [ldst_pkg::LDST_TAG_W-1:0]        res_tag_o,
    output logic [ldst_pkg::LDST_XLEN-1:0]         res_data_o,
    output logic                                   res_fault_o
);

    import ldst_pkg::*;

    logic [LDST_ENTRY_W-1:0] gen_entry;
    logic                    gen_misaligned;
    logic                    head_valid;
    logic [LDST_ENTRY_W:0]   head_data;
    logic                    head_yumi;

    ldst_addr_gen i_ldst_addr_gen (
        .op_i         (disp_op_i),
        .base_i       (disp_base_i),
        .offset_i     (disp_offset_i),
        .payload_i    (disp_payload_i),
        .entry_o      (gen_entry),
        .misaligned_o (gen_misaligned)
    );

    // Misaligned flag rides on top of the entry
    ldst_buffer i_ldst_buffer (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .data_i    ({gen_misaligned, gen_entry}),
        .valid_i   (disp_valid_i),
        .ready_o   (disp_ready_o),
        .valid_o   (head_valid),
        .data_o    (head_data),
        .yumi_i    (head_yumi)
    );

    ldst_mem_ctrl i_ldst_mem_ctrl (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .head_valid_i (head_valid),
        .head_data_i  (head_data),
        .head_yumi_o  (head_yumi),
        .mem_req_o    (mem_req_o),
        .mem_we_o     (mem_we_o),
        .mem_addr_o   (mem_addr_o),
        .mem_be_o     (mem_be_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ack_i    (mem_ack_i),
        .mem_rdata_i  (mem_rdata_i),
        .res_valid_o  (res_valid_o),
        .res_tag_o    (res_tag_o),
        .res_data_o   (res_data_o),
        .res_fault_o  (res_fault_o)
    );

endmodule : ldst_unit

`default_nettype wire

//--- hdl/ldst_mem_ctrl.sv
/*
 * Load/store memory controller
 * Takes the queue head, runs one four-phase req/ack handshake
 * per aligned access and broadcasts load results with their tag
 */
`timescale 1ns/100ps
`default_nettype none

module ldst_mem_ctrl (
    input  wire logic                              clk_i,
    input  wire logic                              reset_n_i,
    input  wire logic                              head_valid_i,
    input  wire logic [ldst_pkg::LDST_ENTRY_W:0]   head_data_i,
    output logic                                   head_yumi_o,
    output logic                                   mem_req_o,
    output logic                                   mem_we_o,
    output logic [ldst_pkg::LDST_XLEN-1:0]         mem_addr_o,
    output logic [3:0]                             mem_be_o,
    output logic [ldst_pkg::LDST_XLEN-1:0]         mem_wdata_o,
    input  wire logic                              mem_ack_i,
    input  wire logic [ldst_pkg::LDST_XLEN-1:0]    mem_rdata_i,
    output logic                                   res_valid_o,
    output logic [ldst_pkg::LDST_TAG_W-1:0]        res_tag_o,
    output logic [ldst_pkg::LDST_XLEN-1:0]         res_data_o,
    output logic                                   res_fault_o
);

    import ldst_pkg::*;

    logic [LDST_ST_W-1:0]   state_r;
    logic [LDST_ST_W-1:0]   state_nxt;
    logic [LDST_ENTRY_W:0]  ent_r;
    logic [LDST_XLEN-1:0]   rdata_r;

    // Fields of the held entry
    logic [LDST_OP_W-1:0]   op;
    logic [LDST_XLEN-1:0]   addr;
    ldst_payload_u          pay;
    logic                   mis;

    logic                   is_store;
    logic                   is_byte;
    logic                   is_half;
    logic                   sign_ext;
    logic [LDST_XLEN-1:0]   lane_data;

    assign op   = ent_r[ENT_OP_LSB +: LDST_OP_W];
    assign addr = ent_r[ENT_ADDR_LSB +: LDST_XLEN];
    assign pay  = ent_r[ENT_PAY_LSB +: LDST_XLEN];
    assign mis  = ent_r[LDST_ENTRY_W];

    // Width and sign decode of the held op
    always_comb begin
        is_store = 1'b0;
        is_byte  = 1'b0;
        is_half  = 1'b0;
        sign_ext = 1'b0;
        case (op)
            OP_LB: begin
                is_byte  = 1'b1;
                sign_ext = 1'b1;
            end
            OP_LH: begin
                is_half  = 1'b1;
                sign_ext = 1'b1;
            end
            OP_LBU: is_byte = 1'b1;
            OP_LHU: is_half = 1'b1;
            OP_SB: begin
                is_store = 1'b1;
                is_byte  = 1'b1;
            end
            OP_SH: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            OP_SW: is_store = 1'b1;
            default: is_store = 1'b0;
        endcase
    end

    // Next state
    always_comb begin
        state_nxt = state_r;
        case (state_r)
            // Misaligned entries bypass memory
            ST_IDLE: if (head_valid_i) state_nxt = ent_mis_next();
            ST_REQ: if (mem_ack_i) state_nxt = ST_RESULT;
            ST_RESULT: state_nxt = mem_ack_i ? ST_WAIT_LOW : ST_IDLE;
            default: if (!mem_ack_i) state_nxt = ST_IDLE;
        endcase
    end

    function automatic logic [LDST_ST_W-1:0] ent_mis_next();
        return head_data_i[LDST_ENTRY_W] ? ST_RESULT : ST_REQ;
    endfunction

    always_ff @(posedge clk_i, negedge reset_n_i) begin
        if (!reset_n_i) begin
            state_r <= ST_IDLE;
        end else begin
            state_r <= state_nxt;
        end
    end

    // Entry taken from the head, read data caught on the first ack edge
    always_ff @(posedge clk_i) begin
        if (head_yumi_o) begin
            ent_r <= head_data_i;
        end
        if (state_r == ST_REQ && mem_ack_i) begin
            rdata_r <= mem_rdata_i;
        end
    end

    assign head_yumi_o = (state_r == ST_IDLE) & head_valid_i;

    // Memory request fields, all from the held entry
    assign mem_req_o  = state_r == ST_REQ;
    assign mem_we_o   = is_store;
    assign mem_addr_o = {addr[LDST_XLEN-1:2], 2'b00};
    always_comb begin
        if (is_byte) begin
            mem_be_o    = 4'b0001 << addr[1:0];
            mem_wdata_o = {4{pay.store_data[7:0]}};
        end else if (is_half) begin
            mem_be_o    = 4'b0011 << {addr[1], 1'b0};
            mem_wdata_o = {2{pay.store_data[15:0]}};
        end else begin
            mem_be_o    = 4'b1111;
            mem_wdata_o = pay.store_data;
        end
    end

    // Shift the addressed lane down, then extend
    assign lane_data = rdata_r >> {addr[1:0], 3'b000};
    always_comb begin
        if (mis) begin
            res_data_o = '0;
        end else if (is_byte) begin
            res_data_o = {{24{sign_ext & lane_data[7]}}, lane_data[7:0]};
        end else if (is_half) begin
            res_data_o = {{16{sign_ext & lane_data[15]}}, lane_data[15:0]};
        end else begin
            res_data_o = rdata_r;
        end
    end

    // Stores pass through the result state without a broadcast
    assign res_valid_o = (state_r == ST_RESULT) & ~is_store;
    assign res_tag_o   = pay.load.dest_tag;
    assign res_fault_o = mis;

    a_req_until_ack: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        mem_req_o && !mem_ack_i |=> mem_req_o);

    a_req_stable: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        mem_req_o && !mem_ack_i |=> $stable(mem_addr_o) && $stable(mem_be_o));

endmodule : ldst_mem_ctrl

`default_nettype wire

//--- hdl/ldst_buffer.sv
/*
 * Load/store ordered queue
 * Circular buffer of LDST_DEPTH entries, valid/ready on the
 * input and valid/yumi on the output, head held in a register
 */
`timescale 1ns/100ps
`default_nettype none

module ldst_buffer (
    input  wire logic                          clk_i,
    input  wire logic                          reset_n_i,

    // Input side, valid/ready
    input  wire logic [ldst_pkg::LDST_ENTRY_W:0] data_i,
    input  wire logic                          valid_i,
    output logic                               ready_o,

    // Output side, valid/yumi
    output logic                               valid_o,
    output logic [ldst_pkg::LDST_ENTRY_W:0]    data_o,
    input  wire logic                          yumi_i
);

    import ldst_pkg::*;

    // Entry storage
    logic [LDST_ENTRY_W:0] queue_r [LDST_DEPTH];

    // Pointers with wrap bit on top
    logic [LDST_PTR_W:0] rd_ptr_r;
    logic [LDST_PTR_W:0] wr_ptr_r;
    logic [LDST_PTR_W:0] rd_ptr_nxt;
    logic [LDST_PTR_W:0] wr_ptr_nxt;
    logic [LDST_PTR_W:0] count;

    logic idx_eq;
    logic wrap_eq;
    logic empty;
    logic full;
    logic enqueue;
    logic dequeue;

    // Head of queue, always ready for the consumer
    logic [LDST_ENTRY_W:0] head_r;

    assign idx_eq  = rd_ptr_r[LDST_PTR_W-1:0] == wr_ptr_r[LDST_PTR_W-1:0];
    assign wrap_eq = rd_ptr_r[LDST_PTR_W] == wr_ptr_r[LDST_PTR_W];
    // Same index, wrap bits tell full from empty
    assign empty   = idx_eq & wrap_eq;
    assign full    = idx_eq & ~wrap_eq;
    assign count   = wr_ptr_r - rd_ptr_r;

    assign ready_o = ~full;
    assign valid_o = ~empty;
    assign data_o  = head_r;

    assign enqueue    = valid_i & ready_o;
    assign dequeue    = yumi_i & valid_o;
    assign rd_ptr_nxt = rd_ptr_r + 1'b1;
    assign wr_ptr_nxt = wr_ptr_r + 1'b1;

    // Pointer update
    always_ff @(posedge clk_i, negedge reset_n_i) begin
        if (!reset_n_i) begin
            rd_ptr_r <= '0;
            wr_ptr_r <= '0;
        end else begin
            if (enqueue) begin
                wr_ptr_r <= wr_ptr_nxt;
            end
            if (dequeue) begin
                rd_ptr_r <= rd_ptr_nxt;
            end
        end
    end

    // Storage and head register
    always_ff @(posedge clk_i) begin
        if (enqueue) begin
            queue_r[wr_ptr_r[LDST_PTR_W-1:0]] <= data_i;
        end
        case ({enqueue, dequeue})
            2'b10: begin
                // First entry into an empty queue goes straight to the head
                if (empty) begin
                    head_r <= data_i;
                end
            end
            2'b01: begin
                head_r <= queue_r[rd_ptr_nxt[LDST_PTR_W-1:0]];
            end
            2'b11: begin
                // With a single item, the incoming word becomes the new head
                if (rd_ptr_nxt[LDST_PTR_W-1:0] == wr_ptr_r[LDST_PTR_W-1:0]) begin
                    head_r <= data_i;
                end else begin
                    head_r <= queue_r[rd_ptr_nxt[LDST_PTR_W-1:0]];
                end
            end
            default: begin
                head_r <= head_r;
            end
        endcase
    end

    // Occupancy never exceeds the depth, so no entry is overwritten
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        count <= LDST_DEPTH);

    // Consumer only takes the head when one is presented
    a_yumi_valid: assert property (@(posedge clk_i) disable iff (!reset_n_i)
        yumi_i |-> valid_o);

endmodule : ldst_buffer

`default_nettype wire

//--- hdl/ldst_addr_gen.sv
/*
 * Load/store address generation
 * Adds base and offset, flags accesses that are not aligned to
 * their width and packs the queue entry word
 */
`timescale 1ns/100ps
`default_nettype none

module ldst_addr_gen (
    input  wire logic [ldst_pkg::LDST_OP_W-1:0] op_i,
    input  wire logic [ldst_pkg::LDST_XLEN-1:0] base_i,
    input  wire logic [ldst_pkg::LDST_XLEN-1:0] offset_i,
    input  wire ldst_pkg::ldst_payload_u        payload_i,
    output logic [ldst_pkg::LDST_ENTRY_W-1:0]   entry_o,
    output logic                                misaligned_o
);

    import ldst_pkg::*;

    logic [LDST_XLEN-1:0] eff_addr;

    // Effective address
    assign eff_addr = base_i + offset_i;

    // Alignment check against the width implied by the op
    always_comb begin
        case (op_i)
            // Halfwords need bit 0 clear
            OP_LH, OP_LHU, OP_SH: misaligned_o = eff_addr[0];
            // Words need both low bits clear
            OP_LW, OP_SW: misaligned_o = |eff_addr[1:0];
            // Bytes are never misaligned
            default: misaligned_o = 1'b0;
        endcase
    end

    // Entry packing
    always_comb begin
        entry_o = '0;
        entry_o[ENT_OP_LSB +: LDST_OP_W]   = op_i;
        entry_o[ENT_ADDR_LSB +: LDST_XLEN] = eff_addr;
        entry_o[ENT_PAY_LSB +: LDST_XLEN]  = payload_i;
    end

endmodule : ldst_addr_gen

`default_nettype wire

//--- hdl/ldst_pkg.sv
/*
 * Load/store unit shared definitions
 * Queue sizing, op codes, queue entry field positions,
 * controller state codes and the dispatch payload union
 */
`default_nettype none

package ldst_pkg;

    // Queue sizing, pointers carry an extra wrap bit above LDST_PTR_W
    localparam int unsigned LDST_DEPTH = 8;
    localparam int unsigned LDST_PTR_W = 3;
    localparam int unsigned LDST_XLEN  = 32;

    // Op codes, loads follow RV32 funct3 and stores use the free codes
    localparam int unsigned LDST_OP_W = 3;
    localparam logic [LDST_OP_W-1:0] OP_LB  = 3'b000;
    localparam logic [LDST_OP_W-1:0] OP_LH  = 3'b001;
    localparam logic [LDST_OP_W-1:0] OP_LW  = 3'b010;
    localparam logic [LDST_OP_W-1:0] OP_SB  = 3'b011;
    localparam logic [LDST_OP_W-1:0] OP_LBU = 3'b100;
    localparam logic [LDST_OP_W-1:0] OP_LHU = 3'b101;
    localparam logic [LDST_OP_W-1:0] OP_SH  = 3'b110;
    localparam logic [LDST_OP_W-1:0] OP_SW  = 3'b111;

    // Entry word is {op, addr, payload}
    localparam int unsigned LDST_ENTRY_W = LDST_OP_W + 2 * LDST_XLEN;
    localparam int unsigned ENT_PAY_LSB  = 0;
    localparam int unsigned ENT_ADDR_LSB = ENT_PAY_LSB + LDST_XLEN;
    localparam int unsigned ENT_OP_LSB   = ENT_ADDR_LSB + LDST_XLEN;
    localparam int unsigned LDST_TAG_W   = 5;

    // Memory controller states
    localparam int unsigned LDST_ST_W = 2;
    localparam logic [LDST_ST_W-1:0] ST_IDLE     = 2'd0;
    localparam logic [LDST_ST_W-1:0] ST_REQ      = 2'd1;
    localparam logic [LDST_ST_W-1:0] ST_RESULT   = 2'd2;
    localparam logic [LDST_ST_W-1:0] ST_WAIT_LOW = 2'd3;

    // Payload word, store data or a load's destination tag
    typedef union packed {
        logic [LDST_XLEN-1:0] store_data;
        struct packed {
            logic [LDST_XLEN-LDST_TAG_W-1:0] pad;
            logic [LDST_TAG_W-1:0]           dest_tag;
        } load;
    } ldst_payload_u;

endpackage : ldst_pkg

`default_nettype wire
